// File: include/sprite_gpu_settings.svh
// Size and address constants of the sprite print engine.
// Include this in any module that needs screen, sprite or slot sizes;
// the include folder must be on the compiler's include path.

`ifndef SPRITE_GPU_SETTINGS_SVH
`define SPRITE_GPU_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// screen geometry
//////////////////////////////////////////////////////////////////////
`define SCREEN_W 640 // visible columns of the display.
`define SCREEN_H 480 // visible rows of the display.

//////////////////////////////////////////////////////////////////////
// sprites
//////////////////////////////////////////////////////////////////////
`define SPRITE_W 20 // sprite width, also the number of addresses per line.
`define SPRITE_H 20 // sprite height in rows.
`define NUM_SPRITES 8 // number of sprite slots in the register bank.

// memory word that holds the background colour.
`define BG_ADDR 115200

`endif

// File: verilog/sprite_gpu_pkg.sv
// Shared types of the sprite print engine.
// Every RTL module pulls these in with a wildcard import in its header.

`default_nettype none

package sprite_gpu_pkg;

	typedef logic [9:0] coord_x_t; // screen column, 0 to 639 when visible.
	typedef logic [8:0] coord_y_t; // screen row, 0 to 479 when visible.
	typedef logic [7:0] sprite_offset_t; // which bitmap in sprite memory.
	typedef logic [16:0] mem_addr_t; // pixel memory address.
	typedef logic [2:0] slot_index_t; // sprite slot number.

	// states of the per-pixel print controller.
	typedef enum logic [1:0] {
		RECEIVE = 2'd0, // waiting for a pixel.
		PROCESS = 2'd1, // bounds and hit are known, choose the output.
		SPRITE = 2'd2, // line counter is emitting a sprite line.
		BACKGROUND = 2'd3 // single background address is offered.
	} print_state_t;

endpackage

`default_nettype wire

// File: verilog/sprite_reg_loader.sv
// Write port of the sprite slot bank.
// Buffers one slot write and releases it as a one-hot strobe only while
// the print controller is idle, so a pixel in flight sees a stable bank.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_reg_loader import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic wr_valid,
	output logic wr_ready,
	input wire slot_index_t wr_slot,
	input wire coord_x_t wr_x,
	input wire coord_y_t wr_y,
	input wire sprite_offset_t wr_offset,
	input wire logic wr_enable,
	input wire logic idle,
	output logic [`NUM_SPRITES-1:0] slot_we,
	output coord_x_t slot_x,
	output coord_y_t slot_y,
	output sprite_offset_t slot_offset,
	output logic slot_enable
);

	logic pend_q; // a write is buffered and not yet applied.
	slot_index_t slot_q; // target slot of the buffered write.
	logic accept; // write handshake completes this cycle.
	logic apply; // buffered write reaches the bank this cycle.

	assign wr_ready = !pend_q; // one write deep, so ready means empty.
	assign accept = wr_valid && wr_ready;
	assign apply = pend_q && idle; // the bank only changes between pixels.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pend_q <= 1'b0;
		end else if (accept) begin
			pend_q <= 1'b1;
		end else if (apply) begin
			pend_q <= 1'b0; // released to the slots this cycle.
		end
	end

	// write data is only looked at while pend_q is set.
	always_ff @(posedge clk) begin
		if (accept) begin
			slot_q <= wr_slot;
			slot_x <= wr_x;
			slot_y <= wr_y;
			slot_offset <= wr_offset;
			slot_enable <= wr_enable; // low here turns the slot off.
		end
	end

	assign slot_we = apply ? (`NUM_SPRITES'(1) << slot_q) : '0; // decode to one strobe.

	// an offered write stays offered and unchanged until it is taken.
	a_wr_hold: assert property (@(posedge clk) disable iff (!reset)
		(wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_slot) && $stable(wr_x)
			&& $stable(wr_y) && $stable(wr_offset) && $stable(wr_enable)));

endmodule

`default_nettype wire

// File: verilog/sprite_slot.sv
// One sprite slot of the register bank.
// Holds position, bitmap offset and enable of a sprite and tells, without
// a clock, whether it covers the check coordinate and where that row of
// the sprite starts in memory.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_slot import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic we,
	input wire coord_x_t slot_x,
	input wire coord_y_t slot_y,
	input wire sprite_offset_t slot_offset,
	input wire logic slot_enable,
	input wire coord_x_t check_x,
	input wire coord_y_t check_y,
	output logic hit,
	output mem_addr_t line_base
);

	coord_x_t x_q; // left column of the sprite.
	coord_y_t y_q; // top row of the sprite.
	sprite_offset_t offset_q; // bitmap number in sprite memory.
	logic en_q; // slot takes part in the hit test.
	logic [10:0] x_end; // first column right of the sprite.
	logic [9:0] y_end; // first row below the sprite.
	logic in_x; // check column lies inside the sprite.
	logic in_y; // check row lies inside the sprite.
	coord_y_t row; // row inside the sprite, valid on a hit.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			en_q <= 1'b0; // all slots start out empty.
		end else if (we) begin
			en_q <= slot_enable;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			x_q <= slot_x;
			y_q <= slot_y;
			offset_q <= slot_offset;
		end
	end

	// the end points get one extra bit so a sprite at the far edge cannot wrap.
	assign x_end = {1'b0, x_q} + 11'(`SPRITE_W);
	assign y_end = {1'b0, y_q} + 10'(`SPRITE_H);

	assign in_x = (check_x >= x_q) && ({1'b0, check_x} < x_end);
	assign in_y = (check_y >= y_q) && ({1'b0, check_y} < y_end);
	assign hit = en_q && in_x && in_y;

	assign row = check_y - y_q; // meaningless when there is no hit.

	// each bitmap is SPRITE_W x SPRITE_H words stored row after row.
	assign line_base = mem_addr_t'(offset_q) * mem_addr_t'(`SPRITE_W * `SPRITE_H)
		+ mem_addr_t'(row) * mem_addr_t'(`SPRITE_W);

endmodule

`default_nettype wire

// File: verilog/sprite_hit_select.sv
// Picks the sprite that is drawn for the current check coordinate.
// The lowest-numbered covering slot wins, so it lies in front, and the
// choice is registered once for the print controller.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_hit_select import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`NUM_SPRITES-1:0] hit,
	input wire mem_addr_t [`NUM_SPRITES-1:0] line_base,
	output logic any_hit,
	output mem_addr_t hit_base
);

	logic sel_hit; // some slot covers the coordinate.
	mem_addr_t sel_base; // line base of the front slot.

	// scanning down from the top leaves the lowest hit in place.
	always_comb begin
		sel_hit = 1'b0;
		sel_base = line_base[0];
		for (int i = `NUM_SPRITES - 1; i >= 0; i--) begin
			if (hit[i]) begin
				sel_hit = 1'b1;
				sel_base = line_base[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			any_hit <= 1'b0;
		end else begin
			any_hit <= sel_hit;
		end
	end

	always_ff @(posedge clk) begin
		hit_base <= sel_base; // only used together with any_hit.
	end

endmodule

`default_nettype wire

// File: verilog/pixel_print_fsm.sv
// Per-pixel print controller.
// Takes one pixel coordinate at a time, asks the slot bank about it and
// then either starts a sprite line, offers the background address or
// drops the pixel when it is off screen. pixel_ready returns at the end.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module pixel_print_fsm import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	output logic pixel_ready,
	input wire coord_x_t pixel_x,
	input wire coord_y_t pixel_y,
	output coord_x_t check_x,
	output coord_y_t check_y,
	input wire logic any_hit,
	input wire mem_addr_t hit_base,
	output logic line_start,
	output mem_addr_t line_base,
	input wire logic line_done,
	output logic bg_valid,
	input wire logic addr_ready,
	output logic idle
);

	print_state_t state; // current controller state.
	print_state_t next_state; // state after this edge.
	coord_x_t px_q; // column of the pixel being printed.
	coord_y_t py_q; // row of the pixel being printed.
	logic accept; // pixel handshake completes this cycle.
	logic on_screen; // held pixel lies in the visible area.

	assign pixel_ready = (state == RECEIVE);
	assign idle = (state == RECEIVE); // the slot bank may change now.
	assign accept = pixel_valid && pixel_ready;

	//////////////////////////////////////////////////////////////////////
	// coordinate register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (accept) begin
			px_q <= pixel_x;
			py_q <= pixel_y;
		end
	end

	// while waiting the slots see the offered pixel, so the selector has
	// its result registered by the time PROCESS is reached.
	assign check_x = (state == RECEIVE) ? pixel_x : px_q;
	assign check_y = (state == RECEIVE) ? pixel_y : py_q;

	assign on_screen = (px_q < 10'(`SCREEN_W)) && (py_q < 9'(`SCREEN_H));

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= RECEIVE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			RECEIVE: begin
				if (accept) next_state = PROCESS;
			end
			PROCESS: begin
				if (!on_screen) begin
					next_state = RECEIVE; // off screen pixels are dropped.
				end else if (any_hit) begin
					next_state = SPRITE;
				end else begin
					next_state = BACKGROUND;
				end
			end
			SPRITE: begin
				if (line_done) next_state = RECEIVE; // last address went out.
			end
			BACKGROUND: begin
				if (addr_ready) next_state = RECEIVE; // the one address is taken.
			end
			default: next_state = RECEIVE;
		endcase
	end

	assign line_start = (state == PROCESS) && on_screen && any_hit; // one cycle pulse.
	assign line_base = hit_base;
	assign bg_valid = (state == BACKGROUND);

	// the counter only ends a line while the controller waits for it in SPRITE.
	a_line_done_in_sprite: assert property (@(posedge clk) disable iff (!reset)
		line_done |-> (state == SPRITE));

endmodule

`default_nettype wire

// File: verilog/sprite_line_counter.sv
// Drives the address stream of the engine.
// On line_start it counts out SPRITE_W rising addresses from the line base,
// one per accepted transfer; otherwise it offers BG_ADDR while bg_valid
// is high.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_line_counter import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic line_start,
	input wire mem_addr_t line_base,
	input wire logic bg_valid,
	output logic addr_valid,
	output mem_addr_t addr,
	input wire logic addr_ready,
	output logic line_done
);

	localparam int CNT_W = $clog2(`SPRITE_W); // wide enough for SPRITE_W - 1.

	logic counting_q; // a sprite line is being emitted.
	logic [CNT_W-1:0] cnt_q; // transfers of this line so far.
	mem_addr_t cur_q; // address currently offered.
	logic xfer; // a sprite address is taken this cycle.
	logic last; // the offered address ends the line.

	assign xfer = counting_q && addr_ready;
	assign last = (cnt_q == CNT_W'(`SPRITE_W - 1));
	assign line_done = xfer && last; // pulses with the final transfer.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			counting_q <= 1'b0;
			cnt_q <= '0;
		end else if (line_start) begin
			counting_q <= 1'b1;
			cnt_q <= '0;
		end else if (xfer) begin
			counting_q <= !last; // stop after SPRITE_W transfers.
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// nothing moves without a transfer, so addr holds under back-pressure.
	always_ff @(posedge clk) begin
		if (line_start) begin
			cur_q <= line_base;
		end else if (xfer) begin
			cur_q <= cur_q + 1'b1;
		end
	end

	assign addr_valid = counting_q || bg_valid;
	assign addr = counting_q ? cur_q : mem_addr_t'(`BG_ADDR);

	a_addr_hold: assert property (@(posedge clk) disable iff (!reset)
		(addr_valid && !addr_ready) |=> (addr_valid && $stable(addr)));

endmodule

`default_nettype wire

// File: verilog/sprite_gpu_top.sv
// Top level of the sprite print engine.
// Pixel coordinates and slot writes come in, memory addresses of sprite
// lines or of the background colour go out, all on valid/ready streams.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_gpu_top import sprite_gpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	output logic pixel_ready,
	input wire coord_x_t pixel_x,
	input wire coord_y_t pixel_y,
	input wire logic wr_valid,
	output logic wr_ready,
	input wire slot_index_t wr_slot,
	input wire coord_x_t wr_x,
	input wire coord_y_t wr_y,
	input wire sprite_offset_t wr_offset,
	input wire logic wr_enable,
	output logic addr_valid,
	input wire logic addr_ready,
	output mem_addr_t addr
);

	logic [`NUM_SPRITES-1:0] slot_we; // one write strobe per slot.
	coord_x_t slot_x; // shared write data for the slots.
	coord_y_t slot_y;
	sprite_offset_t slot_offset;
	logic slot_enable;
	coord_x_t check_x; // coordinate under test in every slot.
	coord_y_t check_y;
	logic [`NUM_SPRITES-1:0] slot_hit;
	mem_addr_t [`NUM_SPRITES-1:0] slot_line_base;
	logic any_hit; // registered selector result.
	mem_addr_t hit_base;
	logic line_start; // controller to counter.
	mem_addr_t line_base;
	logic line_done;
	logic bg_valid;
	logic idle; // controller is between pixels.

	sprite_reg_loader sprite_reg_loader_inst (
		.clk(clk), .reset(reset),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_slot(wr_slot),
		.wr_x(wr_x), .wr_y(wr_y), .wr_offset(wr_offset), .wr_enable(wr_enable),
		.idle(idle), .slot_we(slot_we),
		.slot_x(slot_x), .slot_y(slot_y), .slot_offset(slot_offset),
		.slot_enable(slot_enable)
	);

	for (genvar i = 0; i < `NUM_SPRITES; i++) begin : g_slot
		sprite_slot sprite_slot_inst (
			.clk(clk), .reset(reset), .we(slot_we[i]),
			.slot_x(slot_x), .slot_y(slot_y), .slot_offset(slot_offset),
			.slot_enable(slot_enable), .check_x(check_x), .check_y(check_y),
			.hit(slot_hit[i]), .line_base(slot_line_base[i])
		);
	end

	sprite_hit_select sprite_hit_select_inst (
		.clk(clk), .reset(reset), .hit(slot_hit), .line_base(slot_line_base),
		.any_hit(any_hit), .hit_base(hit_base)
	);

	pixel_print_fsm pixel_print_fsm_inst (
		.clk(clk), .reset(reset),
		.pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.check_x(check_x), .check_y(check_y),
		.any_hit(any_hit), .hit_base(hit_base),
		.line_start(line_start), .line_base(line_base), .line_done(line_done),
		.bg_valid(bg_valid), .addr_ready(addr_ready), .idle(idle)
	);

	sprite_line_counter sprite_line_counter_inst (
		.clk(clk), .reset(reset),
		.line_start(line_start), .line_base(line_base), .bg_valid(bg_valid),
		.addr_valid(addr_valid), .addr(addr), .addr_ready(addr_ready),
		.line_done(line_done)
	);

endmodule

`default_nettype wire

// File: tb/sprite_gpu_tb.sv
// Directed testbench of the sprite print engine.
// Keeps its own model of the slot bank, predicts the addresses of every
// pixel and compares them with the address stream of the DUT.

`timescale 1ns/1ps
`default_nettype none

`include "sprite_gpu_settings.svh"

module sprite_gpu_tb import sprite_gpu_pkg::*; ();

	localparam int MAX_XFERS = 470; // upper bound of address transfers over all tests.
	localparam int CYCLE_LIMIT = MAX_XFERS * 8 + 2000; // run is stopped here.

	logic clk;
	logic reset;
	logic pixel_valid;
	logic pixel_ready;
	coord_x_t pixel_x;
	coord_y_t pixel_y;
	logic wr_valid;
	logic wr_ready;
	slot_index_t wr_slot;
	coord_x_t wr_x;
	coord_y_t wr_y;
	sprite_offset_t wr_offset;
	logic wr_enable;
	logic addr_valid;
	logic addr_ready;
	mem_addr_t addr;

	int m_x[`NUM_SPRITES]; // model of the slot bank.
	int m_y[`NUM_SPRITES];
	int m_off[`NUM_SPRITES];
	bit m_en[`NUM_SPRITES];
	mem_addr_t exp_q[$]; // predicted addresses of the current pixel.
	mem_addr_t got_q[$]; // addresses the DUT handed out for it.
	int stall_pct; // chance in percent that addr_ready is held low.
	int cycles; // clock cycles since time zero.

	sprite_gpu_top sprite_gpu_top_inst (
		.clk(clk), .reset(reset),
		.pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_slot(wr_slot),
		.wr_x(wr_x), .wr_y(wr_y), .wr_offset(wr_offset), .wr_enable(wr_enable),
		.addr_valid(addr_valid), .addr_ready(addr_ready), .addr(addr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// addr_ready is set for the coming edge, so a transfer is known here.
	task automatic drive_addr_ready();
		forever begin
			@(negedge clk);
			if (stall_pct > 0 && int'($urandom_range(99, 0)) < stall_pct) begin
				addr_ready = 1'b0;
			end else begin
				addr_ready = 1'b1;
			end
			if (reset && addr_valid && addr_ready) begin
				got_q.push_back(addr); // taken on the next rising edge.
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic report_failure(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
		if (got != exp) begin
			report_failure($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic check_ready(input bit got, input bit exp, input string what);
		if (got != exp) begin
			report_failure($sformatf("%s is %0b, expected %0b", what, got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model and stimulus
	//////////////////////////////////////////////////////////////////////
	// front slot is the lowest covering one; no slot means background.
	task automatic predict_addresses(input int x, input int y);
		int hit_slot;
		int base;
		exp_q.delete();
		if (x >= `SCREEN_W || y >= `SCREEN_H) return; // dropped, nothing out.
		hit_slot = -1;
		for (int i = 0; i < `NUM_SPRITES; i++) begin
			if (hit_slot < 0 && m_en[i] && x >= m_x[i] && x < m_x[i] + `SPRITE_W
				&& y >= m_y[i] && y < m_y[i] + `SPRITE_H) hit_slot = i;
		end
		if (hit_slot < 0) begin
			exp_q.push_back(mem_addr_t'(`BG_ADDR));
		end else begin
			base = m_off[hit_slot] * `SPRITE_W * `SPRITE_H + (y - m_y[hit_slot]) * `SPRITE_W;
			for (int k = 0; k < `SPRITE_W; k++) exp_q.push_back(mem_addr_t'(base + k));
		end
	endtask

	// returns once the write is accepted; it reaches the slots later.
	task automatic write_slot(input int slot, input int x, input int y, input int off,
		input bit en);
		while (!wr_ready) @(negedge clk);
		wr_slot = slot_index_t'(slot);
		wr_x = coord_x_t'(x);
		wr_y = coord_y_t'(y);
		wr_offset = sprite_offset_t'(off);
		wr_enable = en;
		wr_valid = 1'b1;
		@(negedge clk);
		wr_valid = 1'b0;
		m_x[slot] = x;
		m_y[slot] = y;
		m_off[slot] = off;
		m_en[slot] = en;
	endtask

	task automatic start_pixel(input int x, input int y);
		bit on_screen;
		while (!wr_ready) @(negedge clk); // earlier writes must sit in the bank.
		predict_addresses(x, y);
		on_screen = (exp_q.size() != 0);
		got_q.delete();
		pixel_x = coord_x_t'(x);
		pixel_y = coord_y_t'(y);
		pixel_valid = 1'b1;
		while (!pixel_ready) @(negedge clk);
		@(negedge clk);
		pixel_valid = 1'b0; // accepted on the edge just gone.
		check_ready(pixel_ready, 1'b0, "pixel_ready after acceptance");
		check_ready(addr_valid, 1'b0, "addr_valid one edge after acceptance");
		@(negedge clk);
		check_ready(addr_valid, on_screen, "addr_valid two edges after acceptance");
	endtask

	task automatic finish_pixel(input string what);
		while (!pixel_ready) @(negedge clk);
		check_ready(addr_valid, 1'b0, $sformatf("%s: addr_valid at pixel end", what));
		if (got_q.size() != exp_q.size()) begin
			report_failure($sformatf("%s gave %0d addresses, expected %0d",
				what, got_q.size(), exp_q.size()));
		end
		foreach (exp_q[i]) check_addr(got_q[i], exp_q[i], $sformatf("%s address %0d", what, i));
	endtask

	task automatic print_pixel(input int x, input int y);
		start_pixel(x, y);
		finish_pixel($sformatf("pixel (%0d,%0d)", x, y));
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic run_background_test();
		print_pixel(0, 0);
		print_pixel(639, 479); // last visible pixel.
		print_pixel(320, 240);
		print_pixel(100, 50);
	endtask

	task automatic run_single_slot_test();
		write_slot(2, 100, 60, 5, 1'b1);
		print_pixel(100, 60); // the four corners.
		print_pixel(119, 60);
		print_pixel(100, 79);
		print_pixel(119, 79);
		print_pixel(110, 70);
		print_pixel(99, 60); // one pixel outside on each side.
		print_pixel(120, 70);
		print_pixel(110, 59);
		print_pixel(110, 80);
	endtask

	task automatic run_overlap_test();
		write_slot(1, 300, 200, 3, 1'b1);
		write_slot(4, 310, 205, 7, 1'b1);
		print_pixel(315, 210); // both cover, slot 1 is in front.
		print_pixel(305, 202);
		print_pixel(325, 222);
		write_slot(1, 300, 200, 3, 1'b0);
		print_pixel(315, 210); // now slot 4 shows.
	endtask

	task automatic run_offscreen_test();
		print_pixel(640, 0);
		print_pixel(0, 480);
		print_pixel(1023, 511);
		print_pixel(110, 70); // still in order after the dropped ones.
		print_pixel(0, 0);
	endtask

	task automatic run_stall_test();
		stall_pct = 50;
		print_pixel(100, 60);
		print_pixel(119, 79);
		print_pixel(315, 210);
		print_pixel(500, 400);
		repeat (8) begin
			print_pixel(int'($urandom_range(129, 90)), int'($urandom_range(89, 50)));
		end
		stall_pct = 0;
	endtask

	task automatic run_write_during_line_test();
		start_pixel(110, 70); // slot 2 is printing.
		write_slot(0, 105, 65, 9, 1'b1);
		check_ready(pixel_ready, 1'b0, "pixel_ready while the write was taken");
		finish_pixel("pixel during slot write");
		print_pixel(110, 70); // slot 0 is in front from here on.
	endtask

	initial begin
		void'($urandom(32'h72efd2d4));
		cycles = 0;
		stall_pct = 0;
		reset = 1'b0;
		pixel_valid = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		wr_valid = 1'b0;
		wr_slot = '0;
		wr_x = '0;
		wr_y = '0;
		wr_offset = '0;
		wr_enable = 1'b0;
		addr_ready = 1'b1;
		for (int i = 0; i < `NUM_SPRITES; i++) begin
			m_x[i] = 0;
			m_y[i] = 0;
			m_off[i] = 0;
			m_en[i] = 1'b0; // the bank starts empty.
		end
		fork
			drive_addr_ready(); // stall pattern follows from the seed above.
		join_none
		repeat (16) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		check_ready(pixel_ready, 1'b1, "pixel_ready after reset");
		check_ready(wr_ready, 1'b1, "wr_ready after reset");
		check_ready(addr_valid, 1'b0, "addr_valid after reset");
		run_background_test();
		run_single_slot_test();
		run_overlap_test();
		run_offscreen_test();
		run_stall_test();
		run_write_during_line_test();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: sprite_gpu_top.f
+incdir+include
verilog/sprite_gpu_pkg.sv
verilog/sprite_reg_loader.sv
verilog/sprite_slot.sv
verilog/sprite_hit_select.sv
verilog/pixel_print_fsm.sv
verilog/sprite_line_counter.sv
verilog/sprite_gpu_top.sv
tb/sprite_gpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sprite print engine testbench with Verilator and runs it.
# The exit status is non-zero when the build fails or the testbench fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sprite_gpu_top.f \
	--top-module sprite_gpu_tb \
	-Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vsprite_gpu_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
